//--- rtl/soc_pkg.sv
/* soc package: bus request/response structs, memory map,
   register offsets and the byte-lane merge helper */
package soc_pkg;

  // master to target, valid is a single-cycle strobe
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } bus_req_t;

  // target to master, one cycle after the request
  typedef struct packed {
    logic        valid;
    logic        err;
    logic [31:0] rdata;
  } bus_rsp_t;

  localparam int N_TARGETS = 4;

  typedef enum logic [1:0] {
    TGT_RAM  = 2'd0,
    TGT_UART = 2'd1,
    TGT_RST  = 2'd2,
    TGT_GPIO = 2'd3
  } target_e;

  // region bases, decoded on addr[31:28]
  localparam logic [31:0] RAM_BASE  = 32'h1000_0000;
  localparam logic [31:0] UART_BASE = 32'hB000_0000;
  localparam logic [31:0] RST_BASE  = 32'hC000_0000;
  localparam logic [31:0] GPIO_BASE = 32'hD000_0000;

  // word offsets inside a region
  localparam logic [31:0] UART_TXDATA_OFS = 32'h0;
  localparam logic [31:0] UART_STATUS_OFS = 32'h4;
  localparam logic [31:0] RST_ADDR_OFS    = 32'h0;
  localparam logic [31:0] RST_RUN_OFS     = 32'h4;

  // processor start addresses, picked by the bootloader pin
  localparam logic [31:0] BOOT_ROM_ADDR  = 32'h0000_0000;
  localparam logic [31:0] BOOT_IMEM_ADDR = 32'hA000_0000;

  // replace the byte lanes of old_w selected by strb
  function automatic logic [31:0] merge_wstrb(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  strb);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

endpackage

//--- rtl/bus_xbar.sv
/* bus crossbar: routes each request to one target by address and
   returns its response a cycle later, erroring on unmapped space */
module bus_xbar (
  input  logic               clk,
  input  logic               rst_i,
  input  soc_pkg::bus_req_t  req_i,
  output soc_pkg::bus_rsp_t  rsp_o,
  output soc_pkg::bus_req_t  tgt_req_o [soc_pkg::N_TARGETS],
  input  soc_pkg::bus_rsp_t  tgt_rsp_i [soc_pkg::N_TARGETS]
);

  soc_pkg::target_e sel;
  logic             hit;

  // selection remembered for the response cycle
  soc_pkg::target_e sel_q;
  logic             unmap_q;

  // region decode on the top nibble
  always_comb begin
    sel = soc_pkg::TGT_RAM;
    hit = 1'b1;
    case (req_i.addr[31:28])
      soc_pkg::RAM_BASE[31:28]:  sel = soc_pkg::TGT_RAM;
      soc_pkg::UART_BASE[31:28]: sel = soc_pkg::TGT_UART;
      soc_pkg::RST_BASE[31:28]:  sel = soc_pkg::TGT_RST;
      soc_pkg::GPIO_BASE[31:28]: sel = soc_pkg::TGT_GPIO;
      default:                   hit = 1'b0;
    endcase
  end

  // fan out, only the chosen target sees the strobe
  always_comb begin
    for (int i = 0; i < soc_pkg::N_TARGETS; i++) begin
      tgt_req_o[i]       = req_i;
      tgt_req_o[i].valid = req_i.valid & hit & (sel == soc_pkg::target_e'(i));
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      sel_q   <= soc_pkg::TGT_RAM;
      unmap_q <= 1'b0;
    end else begin
      // hold the last target when idle, its rsp valid is low anyway
      if (req_i.valid && hit) sel_q <= sel;
      unmap_q <= req_i.valid & ~hit;
    end
  end

  // response mux, error beat generated locally
  always_comb begin
    if (unmap_q) begin
      rsp_o.valid = 1'b1;
      rsp_o.err   = 1'b1;
      rsp_o.rdata = 32'd0;
    end else begin
      rsp_o = tgt_rsp_i[sel_q];
    end
  end

endmodule

//--- rtl/bus_ram.sv
/* data RAM target: word array with byte-lane writes and
   registered read data */
module bus_ram #(
  parameter int RAM_KB = 8
) (
  input  logic              clk,
  input  logic              rst_i,
  input  soc_pkg::bus_req_t req_i,
  output soc_pkg::bus_rsp_t rsp_o
);

  localparam int WORDS = RAM_KB * 256;
  localparam int AW    = $clog2(WORDS);

  logic [31:0]   mem [WORDS];
  logic [AW-1:0] idx;

  logic          rsp_valid_q;
  logic [31:0]   rdata_q;

  // word index out of the region offset
  assign idx = req_i.addr[AW+1:2];

  // storage and read port, no reset on the array
  always_ff @(posedge clk) begin
    if (req_i.valid) begin
      if (req_i.write) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.wstrb[b]) mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
        // writes answer with zero data
        rdata_q <= 32'd0;
      end else begin
        rdata_q <= mem[idx];
      end
    end
  end

  // one response per request
  always_ff @(posedge clk) begin
    if (rst_i) rsp_valid_q <= 1'b0;
    else       rsp_valid_q <= req_i.valid;
  end

  assign rsp_o.valid = rsp_valid_q;
  assign rsp_o.err   = 1'b0;
  assign rsp_o.rdata = rdata_q;

endmodule

//--- rtl/bus_uart_tx.sv
/* UART transmit target: 8N1 serializer behind a data register
   and a busy status register */
module bus_uart_tx #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic              clk,
  input  logic              rst_i,
  input  soc_pkg::bus_req_t req_i,
  output soc_pkg::bus_rsp_t rsp_o,
  output logic              uart_tx_o
);

  localparam int CW = $clog2(CLKS_PER_BIT + 1);

  logic          is_txdata;
  logic          is_status;
  logic          tx_start;

  logic          busy_q;
  // stop, data lsb first, start; shifts out of bit 0
  logic [9:0]    frame_q;
  logic [CW-1:0] clk_cnt_q;
  logic [3:0]    bit_cnt_q;

  logic          rsp_valid_q;
  logic          rsp_err_q;
  logic [31:0]   rdata_q;

  assign is_txdata = (req_i.addr[16:0] == soc_pkg::UART_TXDATA_OFS[16:0]);
  assign is_status = (req_i.addr[16:0] == soc_pkg::UART_STATUS_OFS[16:0]);

  // byte accepted only when the line is free
  assign tx_start = req_i.valid & req_i.write & is_txdata & ~busy_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      busy_q    <= 1'b0;
      frame_q   <= '1;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
    end else if (tx_start) begin
      busy_q    <= 1'b1;
      frame_q   <= {1'b1, req_i.wdata[7:0], 1'b0};
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
    end else if (busy_q) begin
      if (clk_cnt_q == CW'(CLKS_PER_BIT - 1)) begin
        clk_cnt_q <= '0;
        // shift in ones so the line idles high
        frame_q   <= {1'b1, frame_q[9:1]};
        if (bit_cnt_q == 4'd9) busy_q <= 1'b0;
        else                   bit_cnt_q <= bit_cnt_q + 4'd1;
      end else begin
        clk_cnt_q <= clk_cnt_q + CW'(1);
      end
    end
  end

  assign uart_tx_o = frame_q[0];

  // response: busy refusal flagged, status reads busy
  always_ff @(posedge clk) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
      rsp_err_q   <= 1'b0;
    end else begin
      rsp_valid_q <= req_i.valid;
      rsp_err_q   <= req_i.valid & req_i.write & is_txdata & busy_q;
    end
  end

  always_ff @(posedge clk) begin
    if (req_i.valid) begin
      if (!req_i.write && is_status) rdata_q <= {31'd0, busy_q};
      else                           rdata_q <= 32'd0;
    end
  end

  assign rsp_o.valid = rsp_valid_q;
  assign rsp_o.err   = rsp_err_q;
  assign rsp_o.rdata = rdata_q;

endmodule

//--- rtl/bus_rst_ctrl.sv
/* reset/boot controller: processor start address and run flag,
   boot address defaults from the bootloader pin */
module bus_rst_ctrl (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              bootloader_i,
  input  soc_pkg::bus_req_t req_i,
  output soc_pkg::bus_rsp_t rsp_o,
  output logic [31:0]       boot_addr_o,
  output logic              cpu_run_o
);

  logic        is_addr;
  logic        is_run;

  logic [31:0] boot_addr_q;
  logic        run_q;
  logic        rsp_valid_q;
  logic [31:0] rdata_q;

  assign is_addr = (req_i.addr[16:0] == soc_pkg::RST_ADDR_OFS[16:0]);
  assign is_run  = (req_i.addr[16:0] == soc_pkg::RST_RUN_OFS[16:0]);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      // imem boot when the loader pin is strapped high
      boot_addr_q <= bootloader_i ? soc_pkg::BOOT_IMEM_ADDR : soc_pkg::BOOT_ROM_ADDR;
      run_q       <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_i.valid;
      if (req_i.valid && req_i.write) begin
        if (is_addr) begin
          boot_addr_q <= soc_pkg::merge_wstrb(boot_addr_q, req_i.wdata, req_i.wstrb);
        end
        // run flag lives in lane 0
        if (is_run && req_i.wstrb[0]) run_q <= req_i.wdata[0];
      end
    end
  end

  // read back both registers, zero elsewhere
  always_ff @(posedge clk) begin
    if (req_i.valid) begin
      if (req_i.write)  rdata_q <= 32'd0;
      else if (is_addr) rdata_q <= boot_addr_q;
      else if (is_run)  rdata_q <= {31'd0, run_q};
      else              rdata_q <= 32'd0;
    end
  end

  assign boot_addr_o = boot_addr_q;
  assign cpu_run_o   = run_q;

  assign rsp_o.valid = rsp_valid_q;
  assign rsp_o.err   = 1'b0;
  assign rsp_o.rdata = rdata_q;

endmodule

//--- rtl/bus_gpio.sv
/* GPIO target: 9-bit output register with read-back */
module bus_gpio (
  input  logic              clk,
  input  logic              rst_i,
  input  soc_pkg::bus_req_t req_i,
  output soc_pkg::bus_rsp_t rsp_o,
  output logic [8:0]        gpio_o
);

  logic [31:0] gpio_wr;
  logic [8:0]  gpio_q;
  logic        rsp_valid_q;
  logic [31:0] rdata_q;

  // lanes 0 and 1 cover the 9 bits, upper lanes fall away
  assign gpio_wr = soc_pkg::merge_wstrb({23'd0, gpio_q}, req_i.wdata, req_i.wstrb);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      gpio_q      <= 9'd0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_i.valid;
      if (req_i.valid && req_i.write) gpio_q <= gpio_wr[8:0];
    end
  end

  always_ff @(posedge clk) begin
    if (req_i.valid) rdata_q <= req_i.write ? 32'd0 : {23'd0, gpio_q};
  end

  assign gpio_o      = gpio_q;
  assign rsp_o.valid = rsp_valid_q;
  assign rsp_o.err   = 1'b0;
  assign rsp_o.rdata = rdata_q;

endmodule

//--- rtl/periph_soc.sv
/* peripheral SoC top: crossbar plus RAM, UART, reset controller
   and GPIO behind one external bus master port */
module periph_soc #(
  parameter int RAM_KB       = 8,
  parameter int CLKS_PER_BIT = 8
) (
  input  logic              clk,
  input  logic              rst_i,
  input  soc_pkg::bus_req_t req_i,
  output soc_pkg::bus_rsp_t rsp_o,
  input  logic              bootloader_i,
  output logic              uart_tx_o,
  output logic [8:0]        gpio_o,
  output logic [31:0]       boot_addr_o,
  output logic              cpu_run_o
);

  // per-target request/response, indexed by target_e
  soc_pkg::bus_req_t tgt_req [soc_pkg::N_TARGETS];
  soc_pkg::bus_rsp_t tgt_rsp [soc_pkg::N_TARGETS];

  bus_xbar u_xbar (
    .clk       (clk),
    .rst_i     (rst_i),
    .req_i     (req_i),
    .rsp_o     (rsp_o),
    .tgt_req_o (tgt_req),
    .tgt_rsp_i (tgt_rsp)
  );

  bus_ram #(
    .RAM_KB (RAM_KB)
  ) u_ram (
    .clk   (clk),
    .rst_i (rst_i),
    .req_i (tgt_req[soc_pkg::TGT_RAM]),
    .rsp_o (tgt_rsp[soc_pkg::TGT_RAM])
  );

  bus_uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uart (
    .clk       (clk),
    .rst_i     (rst_i),
    .req_i     (tgt_req[soc_pkg::TGT_UART]),
    .rsp_o     (tgt_rsp[soc_pkg::TGT_UART]),
    .uart_tx_o (uart_tx_o)
  );

  bus_rst_ctrl u_rst_ctrl (
    .clk          (clk),
    .rst_i        (rst_i),
    .bootloader_i (bootloader_i),
    .req_i        (tgt_req[soc_pkg::TGT_RST]),
    .rsp_o        (tgt_rsp[soc_pkg::TGT_RST]),
    .boot_addr_o  (boot_addr_o),
    .cpu_run_o    (cpu_run_o)
  );

  bus_gpio u_gpio (
    .clk    (clk),
    .rst_i  (rst_i),
    .req_i  (tgt_req[soc_pkg::TGT_GPIO]),
    .rsp_o  (tgt_rsp[soc_pkg::TGT_GPIO]),
    .gpio_o (gpio_o)
  );

endmodule

//--- dv/periph_soc_sva.sv
/* bus and UART protocol checks for periph_soc, attached by bind */
module periph_soc_sva (
  input logic              clk,
  input logic              rst_i,
  input soc_pkg::bus_req_t req_i,
  input soc_pkg::bus_rsp_t rsp_o,
  input logic              uart_tx_o,
  input logic              uart_busy_i
);

  // every request gets its beat exactly one cycle later
  a_rsp_follows_req: assert property (
    @(posedge clk) disable iff (rst_i)
    req_i.valid |=> rsp_o.valid
  ) else $error("response missing one cycle after a request");

  // no beat without a request in the cycle before
  a_no_stray_rsp: assert property (
    @(posedge clk) disable iff (rst_i)
    !req_i.valid |=> !rsp_o.valid
  ) else $error("response without a request");

  // RAM space never errors
  a_ram_no_err: assert property (
    @(posedge clk) disable iff (rst_i)
    (req_i.valid && req_i.addr[31:28] == soc_pkg::RAM_BASE[31:28]) |=> !rsp_o.err
  ) else $error("error response for a RAM address");

  // idle line stays high
  a_tx_idle_high: assert property (
    @(posedge clk) disable iff (rst_i)
    !uart_busy_i |-> uart_tx_o
  ) else $error("uart line low while the transmitter is idle");

endmodule

bind periph_soc periph_soc_sva u_sva (
  .clk         (clk),
  .rst_i       (rst_i),
  .req_i       (req_i),
  .rsp_o       (rsp_o),
  .uart_tx_o   (uart_tx_o),
  .uart_busy_i (u_uart.busy_q)
);

//--- dv/periph_soc_tb.sv
/* periph_soc testbench: bus master model driving RAM, unmapped,
   GPIO, reset controller and UART traffic against a reference model */
module periph_soc_tb;

  localparam int CPB     = 8;
  localparam int RAM_KB  = 8;
  // bus traffic cycles, four uart frames, margin
  localparam int TRAFFIC = 160;
  localparam int TIMEOUT = 10 + TRAFFIC + 4 * 10 * CPB + 200;

  // expected beat, tagged with its request cycle
  typedef struct packed {
    logic        err;
    logic [31:0] rdata;
    int          cyc;
  } exp_t;

  logic              clk = 1'b0;
  logic              rst_i;
  soc_pkg::bus_req_t req_i;
  soc_pkg::bus_rsp_t rsp_o;
  logic              bootloader_i;
  logic              uart_tx_o;
  logic [8:0]        gpio_o;
  logic [31:0]       boot_addr_o;
  logic              cpu_run_o;

  int          seed;
  int          cyc = 0;
  exp_t        exp_q[$];
  logic [31:0] ram_m [int];
  logic [8:0]  gpio_m;
  logic [31:0] boot_m;
  logic        run_m;

  periph_soc #(
    .RAM_KB       (RAM_KB),
    .CLKS_PER_BIT (CPB)
  ) uut (
    .clk          (clk),
    .rst_i        (rst_i),
    .req_i        (req_i),
    .rsp_o        (rsp_o),
    .bootloader_i (bootloader_i),
    .uart_tx_o    (uart_tx_o),
    .gpio_o       (gpio_o),
    .boot_addr_o  (boot_addr_o),
    .cpu_run_o    (cpu_run_o)
  );

  always #2 clk = ~clk;

  task automatic fail_run();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic value_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    fail_run();
  endtask

  // run limit
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT) begin
      $display("timeout: the bus traffic did not finish within %0d cycles", TIMEOUT);
      fail_run();
    end
  end

  // byte lanes of new_w replace those of old_w where strb is set
  function automatic logic [31:0] lane_merge(input logic [31:0] old_w,
                                             input logic [31:0] new_w,
                                             input logic [3:0]  strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  // response checker, beats must match the queue head in order
  always @(negedge clk) begin
    exp_t h;
    if (!rst_i) begin
      if (rsp_o.valid) begin
        assert (exp_q.size() > 0) else value_error("response with no request pending");
        h = exp_q.pop_front();
        assert (h.cyc == cyc - 1) else value_error("response not one cycle after request");
        assert (rsp_o.err == h.err && rsp_o.rdata == h.rdata)
          else value_error($sformatf("rsp err=%0b rdata=%h, expected err=%0b rdata=%h",
                                     rsp_o.err, rsp_o.rdata, h.err, h.rdata));
      end else if (exp_q.size() > 0) begin
        assert (exp_q[0].cyc >= cyc) else value_error("expected response did not arrive");
      end
    end
  end

  // one request on the falling edge, expected beat queued
  task automatic bus_op(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                        input logic [3:0] strb, input logic exp_err,
                        input logic [31:0] exp_rdata);
    exp_t e;
    @(negedge clk);
    req_i.valid = 1'b1;
    req_i.write = wr;
    req_i.addr  = addr;
    req_i.wdata = wdata;
    req_i.wstrb = strb;
    e.err   = exp_err;
    e.rdata = exp_rdata;
    e.cyc   = cyc;
    exp_q.push_back(e);
  endtask

  task automatic idle();
    @(negedge clk);
    req_i = '0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  task automatic ram_write(input int idx, input logic [31:0] wdata, input logic [3:0] strb);
    logic [31:0] old_w;
    old_w = ram_m.exists(idx) ? ram_m[idx] : 32'd0;
    ram_m[idx] = lane_merge(old_w, wdata, strb);
    bus_op(1'b1, soc_pkg::RAM_BASE + 32'(idx * 4), wdata, strb, 1'b0, 32'd0);
  endtask

  task automatic ram_read(input int idx);
    bus_op(1'b0, soc_pkg::RAM_BASE + 32'(idx * 4), 32'd0, 4'h0, 1'b0, ram_m[idx]);
  endtask

  task automatic check_pins();
    assert (gpio_o == gpio_m)
      else value_error($sformatf("gpio_o=%h expected %h", gpio_o, gpio_m));
    assert (boot_addr_o == boot_m)
      else value_error($sformatf("boot_addr_o=%h expected %h", boot_addr_o, boot_m));
    assert (cpu_run_o == run_m)
      else value_error($sformatf("cpu_run_o=%0b expected %0b", cpu_run_o, run_m));
  endtask

  // one frame: line sampled mid-bit while busy is probed on the bus
  task automatic uart_frame(input logic [7:0] b);
    fork
      begin
        @(negedge uart_tx_o);
        repeat (CPB / 2) @(negedge clk);
        assert (uart_tx_o == 1'b0) else value_error("uart start bit not low");
        for (int i = 0; i < 8; i++) begin
          repeat (CPB) @(negedge clk);
          assert (uart_tx_o == b[i])
            else value_error($sformatf("uart data bit %0d wrong for byte %h", i, b));
        end
        repeat (CPB) @(negedge clk);
        assert (uart_tx_o == 1'b1) else value_error("uart stop bit not high");
      end
      begin
        bus_op(1'b1, soc_pkg::UART_BASE + soc_pkg::UART_TXDATA_OFS, {24'd0, b}, 4'h1,
               1'b0, 32'd0);
        bus_op(1'b0, soc_pkg::UART_BASE + soc_pkg::UART_STATUS_OFS, 32'd0, 4'h0,
               1'b0, 32'd1);
        // refused while busy
        bus_op(1'b1, soc_pkg::UART_BASE + soc_pkg::UART_TXDATA_OFS, 32'h5A, 4'h1,
               1'b1, 32'd0);
        idle();
      end
    join
    // let the stop bit end
    repeat (CPB) @(negedge clk);
    bus_op(1'b0, soc_pkg::UART_BASE + soc_pkg::UART_STATUS_OFS, 32'd0, 4'h0, 1'b0, 32'd0);
    idle();
    drain();
  endtask

  initial begin
    logic [31:0] r;
    int          idx;
    seed         = 65271;
    req_i        = '0;
    bootloader_i = 1'b1;
    rst_i        = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;

    // reset state, loader pin strapped high so imem boot
    gpio_m = 9'd0;
    boot_m = soc_pkg::BOOT_IMEM_ADDR;
    run_m  = 1'b0;
    @(negedge clk);
    check_pins();
    assert (rsp_o.valid == 1'b0) else value_error("rsp_o.valid high after reset");
    assert (uart_tx_o == 1'b1) else value_error("uart_tx_o not idle after reset");

    // RAM fill, random lane writes, read back, all back to back
    for (int i = 0; i < 16; i++) begin
      r = $random(seed);
      ram_write(i, r, 4'hF);
    end
    for (int i = 0; i < 24; i++) begin
      r   = $random(seed);
      idx = int'($unsigned($random(seed)) % 16);
      ram_write(idx, r, r[7:4]);
    end
    for (int i = 0; i < 16; i++) ram_read(i);
    idle();
    drain();

    // unmapped space, mapped request right behind it
    bus_op(1'b1, 32'h5000_0000, 32'hDEAD_BEEF, 4'hF, 1'b1, 32'd0);
    bus_op(1'b0, 32'h5000_0000, 32'd0, 4'h0, 1'b1, 32'd0);
    ram_read(3);
    bus_op(1'b0, 32'hF000_0010, 32'd0, 4'h0, 1'b1, 32'd0);
    ram_read(7);
    idle();
    drain();

    // GPIO, full and lane 0 only
    gpio_m = 9'h1A5;
    bus_op(1'b1, soc_pkg::GPIO_BASE, 32'h0000_01A5, 4'h3, 1'b0, 32'd0);
    bus_op(1'b0, soc_pkg::GPIO_BASE, 32'd0, 4'h0, 1'b0, {23'd0, gpio_m});
    idle();
    check_pins();
    gpio_m = 9'h1FF;
    bus_op(1'b1, soc_pkg::GPIO_BASE, 32'hFFFF_FEFF, 4'h1, 1'b0, 32'd0);
    bus_op(1'b0, soc_pkg::GPIO_BASE, 32'd0, 4'h0, 1'b0, {23'd0, gpio_m});
    idle();
    check_pins();

    // reset controller registers
    boot_m = 32'h8000_1234;
    bus_op(1'b1, soc_pkg::RST_BASE + soc_pkg::RST_ADDR_OFS, boot_m, 4'hF, 1'b0, 32'd0);
    run_m = 1'b1;
    bus_op(1'b1, soc_pkg::RST_BASE + soc_pkg::RST_RUN_OFS, 32'd1, 4'h1, 1'b0, 32'd0);
    bus_op(1'b0, soc_pkg::RST_BASE + soc_pkg::RST_ADDR_OFS, 32'd0, 4'h0, 1'b0, boot_m);
    bus_op(1'b0, soc_pkg::RST_BASE + soc_pkg::RST_RUN_OFS, 32'd0, 4'h0, 1'b0, 32'd1);
    idle();
    check_pins();
    run_m = 1'b0;
    bus_op(1'b1, soc_pkg::RST_BASE + soc_pkg::RST_RUN_OFS, 32'd0, 4'h1, 1'b0, 32'd0);
    idle();
    check_pins();
    drain();

    // UART frames, fixed and random byte
    uart_frame(8'hA3);
    r = $random(seed);
    uart_frame(r[7:0]);

    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- periph_soc.f
rtl/soc_pkg.sv
rtl/bus_xbar.sv
rtl/bus_ram.sv
rtl/bus_uart_tx.sv
rtl/bus_rst_ctrl.sv
rtl/bus_gpio.sv
rtl/periph_soc.sv
dv/periph_soc_sva.sv
dv/periph_soc_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the periph_soc testbench with Verilator
verilator --binary --timing --assert --top-module periph_soc_tb -f periph_soc.f \
  -o periph_soc_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/periph_soc_sim > sim.log 2>&1
cat sim.log
grep -q "^PASS: all tests$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
